//--- tb.f
source/pic_types_pkg.sv
source/pic_command_pkg.sv
source/pic_init_registers.sv
source/pic_operation_registers.sv
source/pic_acknowledge_sequencer.sv
source/pic_control_logic.sv
test/tb_pic_control_logic.sv

//--- Makefile
BINARY := obj_dir/Vtb_pic_control_logic

all: run

$(BINARY): tb.f $(wildcard source/*.sv test/*.sv)
	verilator --binary --timing --assert --top-module tb_pic_control_logic -f tb.f -Mdir obj_dir

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf obj_dir

.PHONY: all run clean

//--- test/tb_pic_control_logic.sv
`default_nettype none

module tb_pic_control_logic
	import pic_types_pkg::*;
	import pic_command_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int watchdog_cycles = 400; // the full run takes under 80 cycles.

	typedef enum {icw1_port, icw2_4_port, ocw1_port, ocw2_port, ocw3_port} write_port_t;

	logic clock;
	logic reset;
	data_byte_t internal_data_bus;
	logic write_initial_command_word_1;
	logic write_initial_command_word_2_4;
	logic write_operation_control_word_1;
	logic write_operation_control_word_2;
	logic write_operation_control_word_3;
	logic interrupt_acknowledge_n;
	logic read;
	level_mask_t interrupt;
	level_mask_t highest_level_in_service;
	logic command_ready;
	logic level_or_edge_triggered_config;
	logic special_fully_nest_config;
	logic auto_eoi_config;
	vector_base_t vector_base;
	level_mask_t interrupt_mask;
	level_mask_t end_of_interrupt;
	level_index_t priority_rotate;
	logic enable_read_register;
	logic read_register_isr_or_irr;
	logic poll_command;
	logic interrupt_to_cpu;
	logic latch_in_service;
	level_mask_t clear_interrupt_request;
	logic freeze;
	level_mask_t acknowledge_interrupt;
	logic end_of_acknowledge_sequence;
	logic out_control_logic_data;
	data_byte_t control_logic_data;

	logic [1:0] init_step; // 0 ready, 1 waits for icw2, 2 waits for icw4.
	logic icw4_expected;
	level_mask_t expected_mask;
	data_byte_t last_bus;
	level_mask_t last_his;
	logic [1:0] ack_phase; // 0 idle, 1 and 2 the two inta pulses, 3 poll.
	vector_base_t base_written;
	logic auto_eoi_written;
	level_index_t ack_index;
	level_mask_t ack_mask;
	logic [7:0] lfsr_state;
	logic ocw2_accepted;
	logic ocw3_accepted;
	logic [2:0] ocw2_code;

	pic_control_logic dut (.*);

	assign ocw2_accepted = write_operation_control_word_2 && (init_step == 2'd0);
	assign ocw3_accepted = write_operation_control_word_3 && (init_step == 2'd0);
	assign ocw2_code = internal_data_bus[ocw2_code_lsb +: 3];

	function automatic logic [7:0] galois_step(input logic [7:0] state);
		return {1'b0, state[7:1]} ^ (state[0] ? 8'hb8 : 8'h00);
	endfunction

	task automatic take_bits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = galois_step(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
	endtask

	function automatic level_index_t lowest_level(input level_mask_t mask);
		int index;
		index = 0;
		while ((index < 7) && !mask[index]) begin
			index++;
		end
		return level_index_t'(index);
	endfunction

	task automatic value_error(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
		$display("TEST FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic send_word(input write_port_t port, input data_byte_t value);
		internal_data_bus = value;
		case (port)
			icw1_port: write_initial_command_word_1 = 1'b1;
			icw2_4_port: write_initial_command_word_2_4 = 1'b1;
			ocw1_port: write_operation_control_word_1 = 1'b1;
			ocw2_port: write_operation_control_word_2 = 1'b1;
			default: write_operation_control_word_3 = 1'b1;
		endcase
		next_cycle();
		write_initial_command_word_1 = 1'b0;
		write_initial_command_word_2_4 = 1'b0;
		write_operation_control_word_1 = 1'b0;
		write_operation_control_word_2 = 1'b0;
		write_operation_control_word_3 = 1'b0;
		internal_data_bus = '0;
	endtask

	// expected init sequence and mask.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			init_step <= 2'd0;
			icw4_expected <= 1'b0;
			expected_mask <= '1;
		end else begin
			if (write_initial_command_word_1) begin
				init_step <= 2'd1;
				icw4_expected <= internal_data_bus[icw1_ic4_bit];
			end else if (write_initial_command_word_2_4 && (init_step == 2'd1)) begin
				init_step <= icw4_expected ? 2'd2 : 2'd0;
			end else if (write_initial_command_word_2_4 && (init_step == 2'd2)) begin
				init_step <= 2'd0;
			end
			if (write_operation_control_word_1 && (init_step == 2'd0)) begin
				expected_mask <= internal_data_bus;
			end
		end
	end

	always_ff @(posedge clock) begin
		last_bus <= internal_data_bus;
		last_his <= highest_level_in_service;
	end

	assert property (@(posedge clock) disable iff (reset) interrupt_mask == expected_mask)
		else value_error("interrupt_mask", 16'($sampled(expected_mask)),
			16'($sampled(interrupt_mask)));
	assert property (@(posedge clock) disable iff (reset) command_ready == (init_step == 2'd0))
		else value_error("command_ready", 16'($sampled(init_step) == 2'd0),
			16'($sampled(command_ready)));
	assert property (@(posedge clock) disable iff (reset)
		write_initial_command_word_1 |-> clear_interrupt_request == 8'hff)
		else value_error("clear_interrupt_request", 16'hff, 16'($sampled(clear_interrupt_request)));
	assert property (@(posedge clock) disable iff (reset) write_initial_command_word_1
		|=> level_or_edge_triggered_config == last_bus[icw1_ltim_bit])
		else value_error("level_or_edge_triggered_config", 16'($sampled(last_bus[icw1_ltim_bit])),
			16'($sampled(level_or_edge_triggered_config)));
	assert property (@(posedge clock) disable iff (reset)
		write_initial_command_word_2_4 && (init_step == 2'd1) |=> vector_base == last_bus[7:3])
		else value_error("vector_base", 16'($sampled(last_bus[7:3])),
			16'($sampled(vector_base)));
	assert property (@(posedge clock) disable iff (reset)
		write_initial_command_word_2_4 && (init_step == 2'd2) |=> {special_fully_nest_config,
		auto_eoi_config} == {last_bus[icw4_sfnm_bit], last_bus[icw4_aeoi_bit]})
		else value_error("special_fully_nest_config, auto_eoi_config",
			16'({$sampled(last_bus[icw4_sfnm_bit]), $sampled(last_bus[icw4_aeoi_bit])}),
			16'({$sampled(special_fully_nest_config), $sampled(auto_eoi_config)}));
	assert property (@(posedge clock) disable iff (reset) ocw3_accepted
		|=> {enable_read_register, read_register_isr_or_irr} == last_bus[ocw3_rr_bit -: 2])
		else value_error("enable_read_register, read_register_isr_or_irr",
			16'($sampled(last_bus[ocw3_rr_bit -: 2])),
			16'({$sampled(enable_read_register), $sampled(read_register_isr_or_irr)}));
	assert property (@(posedge clock) disable iff (reset)
		ocw3_accepted && internal_data_bus[ocw3_poll_bit] |-> poll_command)
		else value_error("poll_command", 16'd1, 16'($sampled(poll_command)));
	assert property (@(posedge clock) disable iff (reset) ocw2_accepted
		&& (ocw2_code == ocw2_nonspecific_eoi) |-> end_of_interrupt == highest_level_in_service)
		else value_error("end_of_interrupt", 16'($sampled(highest_level_in_service)),
			16'($sampled(end_of_interrupt)));
	assert property (@(posedge clock) disable iff (reset) ocw2_accepted && (ocw2_code ==
		ocw2_specific_eoi) |-> end_of_interrupt == (8'h01 << internal_data_bus[2:0]))
		else value_error("end_of_interrupt", 16'(8'h01 << $sampled(internal_data_bus[2:0])),
			16'($sampled(end_of_interrupt)));
	assert property (@(posedge clock) disable iff (reset) ocw2_accepted
		&& (ocw2_code[2:1] == ocw2_set_priority) |=> priority_rotate == last_bus[2:0])
		else value_error("priority_rotate", 16'($sampled(last_bus[2:0])),
			16'($sampled(priority_rotate)));
	assert property (@(posedge clock) disable iff (reset) ocw2_accepted
		&& (ocw2_code == ocw2_rotate_on_eoi) |=> priority_rotate == lowest_level(last_his))
		else value_error("priority_rotate", 16'(lowest_level($sampled(last_his))),
			16'($sampled(priority_rotate)));
	assert property (@(posedge clock) disable iff (reset) interrupt != '0 |=> interrupt_to_cpu)
		else value_error("interrupt_to_cpu", 16'd1, 16'($sampled(interrupt_to_cpu)));
	assert property (@(posedge clock) disable iff (reset)
		$fell(interrupt_acknowledge_n) && (ack_phase == 2'd1) |-> latch_in_service)
		else value_error("latch_in_service", 16'd1, 16'($sampled(latch_in_service)));
	assert property (@(posedge clock) disable iff (reset) $fell(interrupt_acknowledge_n)
		&& (ack_phase == 2'd1) |-> clear_interrupt_request == interrupt)
		else value_error("clear_interrupt_request", 16'($sampled(interrupt)),
			16'($sampled(clear_interrupt_request)));
	assert property (@(posedge clock) disable iff (reset) $fell(interrupt_acknowledge_n)
		&& (ack_phase == 2'd1) |=> acknowledge_interrupt == ack_mask)
		else value_error("acknowledge_interrupt", 16'($sampled(ack_mask)),
			16'($sampled(acknowledge_interrupt)));
	assert property (@(posedge clock) disable iff (reset)
		$fell(interrupt_acknowledge_n) && (ack_phase == 2'd1) |=> freeze)
		else value_error("freeze", 16'd1, 16'($sampled(freeze)));
	assert property (@(posedge clock) disable iff (reset)
		(ack_phase == 2'd2) && !interrupt_acknowledge_n |-> freeze)
		else value_error("freeze", 16'd1, 16'($sampled(freeze)));
	assert property (@(posedge clock) disable iff (reset) (ack_phase == 2'd2)
		&& !interrupt_acknowledge_n |-> {out_control_logic_data, control_logic_data}
		== {1'b1, base_written, ack_index})
		else value_error("control_logic_data", 16'({1'b1, $sampled(base_written),
			$sampled(ack_index)}), 16'({$sampled(out_control_logic_data),
			$sampled(control_logic_data)}));
	assert property (@(posedge clock) disable iff (reset)
		$rose(interrupt_acknowledge_n) && (ack_phase == 2'd2) |-> end_of_acknowledge_sequence)
		else value_error("end_of_acknowledge_sequence", 16'd1,
			16'($sampled(end_of_acknowledge_sequence)));
	assert property (@(posedge clock) disable iff (reset) $rose(interrupt_acknowledge_n)
		&& (ack_phase == 2'd2) |-> end_of_interrupt == (auto_eoi_written ? ack_mask : 8'h00))
		else value_error("end_of_interrupt",
			16'($sampled(auto_eoi_written) ? $sampled(ack_mask) : 8'h00),
			16'($sampled(end_of_interrupt)));
	assert property (@(posedge clock) disable iff (reset) $rose(interrupt_acknowledge_n)
		&& (ack_phase == 2'd2) |=> acknowledge_interrupt == '0)
		else value_error("acknowledge_interrupt", 16'h0000,
			16'($sampled(acknowledge_interrupt)));
	assert property (@(posedge clock) disable iff (reset) $rose(interrupt_acknowledge_n)
		&& (ack_phase == 2'd2) && (interrupt == '0) |=> !interrupt_to_cpu)
		else value_error("interrupt_to_cpu", 16'd0, 16'($sampled(interrupt_to_cpu)));
	assert property (@(posedge clock) disable iff (reset) (ack_phase == 2'd3) && read
		|-> {out_control_logic_data, control_logic_data} == {1'b1, 5'b10000, ack_index})
		else value_error("control_logic_data", 16'({1'b1, 5'b10000, $sampled(ack_index)}),
			16'({$sampled(out_control_logic_data), $sampled(control_logic_data)}));
	assert property (@(posedge clock) disable iff (reset) $fell(read) && (ack_phase == 2'd3)
		|=> {out_control_logic_data, control_logic_data} == 9'h000)
		else value_error("control_logic_data", 16'h0000,
			16'({$sampled(out_control_logic_data), $sampled(control_logic_data)}));

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Error: watchdog expired after %0d cycles, the tests did not finish",
			watchdog_cycles);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		logic [7:0] random_value;
		lfsr_state = 8'd78;
		reset = 1'b1;
		internal_data_bus = '0;
		write_initial_command_word_1 = 1'b0;
		write_initial_command_word_2_4 = 1'b0;
		write_operation_control_word_1 = 1'b0;
		write_operation_control_word_2 = 1'b0;
		write_operation_control_word_3 = 1'b0;
		interrupt_acknowledge_n = 1'b1;
		read = 1'b0;
		interrupt = '0;
		highest_level_in_service = '0;
		ack_phase = 2'd0;
		base_written = '0;
		auto_eoi_written = 1'b0;
		ack_index = '0;
		ack_mask = '0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		next_cycle();

		send_word(icw1_port, 8'h19); // ltim and ic4.
		take_bits(8, random_value);
		send_word(ocw1_port, random_value); // dropped while init is still running.
		take_bits(5, random_value);
		base_written = random_value[4:0];
		send_word(icw2_4_port, {base_written, 3'b000});
		auto_eoi_written = 1'b1;
		send_word(icw2_4_port, 8'h13); // sfnm, aeoi and 8086.
		next_cycle();

		take_bits(8, random_value);
		send_word(ocw1_port, random_value);
		next_cycle();

		repeat (3) begin
			take_bits(3, random_value);
			ack_index = random_value[2:0];
			ack_mask = 8'h01 << ack_index;
			interrupt = ack_mask;
			repeat (2) next_cycle();
			ack_phase = 2'd1;
			interrupt_acknowledge_n = 1'b0;
			repeat (2) next_cycle();
			interrupt_acknowledge_n = 1'b1;
			repeat (2) next_cycle();
			ack_phase = 2'd2;
			interrupt = '0;
			interrupt_acknowledge_n = 1'b0;
			repeat (2) next_cycle();
			interrupt_acknowledge_n = 1'b1;
			repeat (2) next_cycle();
			ack_phase = 2'd0;
			next_cycle();
		end

		repeat (2) begin
			take_bits(3, random_value);
			highest_level_in_service = 8'h01 << random_value[2:0];
			send_word(ocw2_port, {ocw2_nonspecific_eoi, 5'b00000});
			take_bits(3, random_value);
			send_word(ocw2_port, {ocw2_specific_eoi, 2'b00, random_value[2:0]});
			take_bits(3, random_value);
			send_word(ocw2_port, {ocw2_set_priority, 3'b000, random_value[2:0]});
			send_word(ocw2_port, {ocw2_rotate_on_eoi, 5'b00000});
			next_cycle();
		end

		send_word(ocw3_port, 8'h0b);
		send_word(ocw3_port, 8'h0a);
		take_bits(3, random_value);
		ack_index = random_value[2:0];
		interrupt = 8'h01 << ack_index;
		ack_phase = 2'd3;
		send_word(ocw3_port, 8'h0c); // poll.
		interrupt = '0;
		read = 1'b1;
		repeat (2) next_cycle();
		read = 1'b0;
		repeat (2) next_cycle();
		ack_phase = 2'd0;
		next_cycle();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/pic_control_logic.sv
`default_nettype none

module pic_control_logic
	import pic_types_pkg::*;
(
	input logic clock,
	input logic reset,
	input data_byte_t internal_data_bus,
	input logic write_initial_command_word_1,
	input logic write_initial_command_word_2_4,
	input logic write_operation_control_word_1,
	input logic write_operation_control_word_2,
	input logic write_operation_control_word_3,
	input logic interrupt_acknowledge_n,
	input logic read,
	input level_mask_t interrupt,
	input level_mask_t highest_level_in_service,
	output logic command_ready,
	output logic level_or_edge_triggered_config,
	output logic special_fully_nest_config,
	output logic auto_eoi_config,
	output vector_base_t vector_base,
	output level_mask_t interrupt_mask,
	output level_mask_t end_of_interrupt,
	output level_index_t priority_rotate,
	output logic enable_read_register,
	output logic read_register_isr_or_irr,
	output logic poll_command,
	output logic interrupt_to_cpu,
	output logic latch_in_service,
	output level_mask_t clear_interrupt_request,
	output logic freeze,
	output level_mask_t acknowledge_interrupt,
	output logic end_of_acknowledge_sequence,
	output logic out_control_logic_data,
	output data_byte_t control_logic_data
);

	pic_init_registers u_init_registers (.*);

	pic_operation_registers u_operation_registers (.*);

	pic_acknowledge_sequencer u_acknowledge_sequencer (.*);

endmodule

`default_nettype wire

//--- source/pic_acknowledge_sequencer.sv
`default_nettype none

module pic_acknowledge_sequencer
	import pic_types_pkg::*;
	import pic_command_pkg::*;
(
	input logic clock,
	input logic reset,
	input level_mask_t interrupt,
	input logic interrupt_acknowledge_n,
	input logic read,
	input logic poll_command,
	input logic write_initial_command_word_1,
	input vector_base_t vector_base,
	output logic interrupt_to_cpu,
	output logic latch_in_service,
	output level_mask_t clear_interrupt_request,
	output logic freeze,
	output level_mask_t acknowledge_interrupt,
	output logic end_of_acknowledge_sequence,
	output logic out_control_logic_data,
	output data_byte_t control_logic_data
);

	ack_state_t state;
	ack_state_t next_state;
	logic prev_interrupt_acknowledge_n;
	logic prev_read;
	logic nedge_interrupt_acknowledge;
	logic pedge_interrupt_acknowledge;
	logic nedge_read;
	logic end_of_poll_command;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			prev_interrupt_acknowledge_n <= 1'b1;
			prev_read <= 1'b0;
		end else begin
			prev_interrupt_acknowledge_n <= interrupt_acknowledge_n;
			prev_read <= read;
		end
	end

	assign nedge_interrupt_acknowledge = prev_interrupt_acknowledge_n && !interrupt_acknowledge_n;
	assign pedge_interrupt_acknowledge = !prev_interrupt_acknowledge_n && interrupt_acknowledge_n;
	assign nedge_read = prev_read && !read;

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (poll_command) begin
					next_state = poll;
				end else if (nedge_interrupt_acknowledge) begin
					next_state = ack_first;
				end
			end
			ack_first: begin
				if (pedge_interrupt_acknowledge) begin
					next_state = ack_second;
				end
			end
			ack_second: begin
				if (pedge_interrupt_acknowledge) begin
					next_state = idle;
				end
			end
			poll: begin
				if (nedge_read) begin
					next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	assign latch_in_service = (state == idle) && (next_state != idle);
	assign end_of_acknowledge_sequence = (state == ack_second) && (next_state == idle);
	assign end_of_poll_command = (state == poll) && (next_state == idle);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			interrupt_to_cpu <= 1'b0;
			freeze <= 1'b1;
			acknowledge_interrupt <= '0;
		end else begin
			if (interrupt != '0) begin
				interrupt_to_cpu <= 1'b1;
			end else if (end_of_acknowledge_sequence || end_of_poll_command) begin
				interrupt_to_cpu <= 1'b0;
			end
			freeze <= (next_state != idle);
			if (end_of_acknowledge_sequence || end_of_poll_command) begin
				acknowledge_interrupt <= '0;
			end else if (latch_in_service) begin
				acknowledge_interrupt <= interrupt;
			end
		end
	end

	always_comb begin
		if (write_initial_command_word_1) begin
			clear_interrupt_request = '1; // initialization drops all pending requests.
		end else if (latch_in_service) begin
			clear_interrupt_request = interrupt;
		end else begin
			clear_interrupt_request = '0;
		end
	end

	always_comb begin
		out_control_logic_data = 1'b0;
		control_logic_data = '0;
		if ((state == ack_second) && !interrupt_acknowledge_n) begin
			out_control_logic_data = 1'b1;
			control_logic_data = {vector_base, mask_to_level(acknowledge_interrupt)};
		end else if ((state == poll) && read) begin
			out_control_logic_data = 1'b1;
			if (acknowledge_interrupt != '0) begin
				control_logic_data = {poll_marker, mask_to_level(acknowledge_interrupt)};
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pic_operation_registers.sv
`default_nettype none

module pic_operation_registers
	import pic_types_pkg::*;
	import pic_command_pkg::*;
(
	input logic clock,
	input logic reset,
	input data_byte_t internal_data_bus,
	input logic write_operation_control_word_1,
	input logic write_operation_control_word_2,
	input logic write_operation_control_word_3,
	input logic command_ready,
	input logic auto_eoi_config,
	input logic end_of_acknowledge_sequence,
	input level_mask_t acknowledge_interrupt,
	input level_mask_t highest_level_in_service,
	output level_mask_t interrupt_mask,
	output level_mask_t end_of_interrupt,
	output level_index_t priority_rotate,
	output logic enable_read_register,
	output logic read_register_isr_or_irr,
	output logic poll_command
);

	logic ocw1_write;
	logic ocw2_write;
	logic ocw3_write;
	logic [2:0] ocw2_code;
	level_index_t ocw2_level;
	logic auto_rotate_mode;

	// writes during initialization are dropped.
	assign ocw1_write = write_operation_control_word_1 && command_ready;
	assign ocw2_write = write_operation_control_word_2 && command_ready;
	assign ocw3_write = write_operation_control_word_3 && command_ready;

	assign ocw2_code = internal_data_bus[ocw2_code_lsb +: 3];
	assign ocw2_level = internal_data_bus[ocw2_level_lsb +: level_index_width];

	assign poll_command = ocw3_write && internal_data_bus[ocw3_poll_bit];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			interrupt_mask <= '1;
			enable_read_register <= 1'b1;
			read_register_isr_or_irr <= 1'b0;
		end else begin
			if (ocw1_write) begin
				interrupt_mask <= internal_data_bus;
			end
			if (ocw3_write) begin
				enable_read_register <= internal_data_bus[ocw3_rr_bit];
				read_register_isr_or_irr <= internal_data_bus[ocw3_ris_bit];
			end
		end
	end

	always_comb begin
		end_of_interrupt = '0;
		if (auto_eoi_config && end_of_acknowledge_sequence) begin
			end_of_interrupt = acknowledge_interrupt;
		end else if (ocw2_write) begin
			if ((ocw2_code == ocw2_nonspecific_eoi) || (ocw2_code == ocw2_rotate_on_eoi)) begin
				end_of_interrupt = highest_level_in_service;
			end else if (ocw2_code == ocw2_specific_eoi) begin
				end_of_interrupt = level_to_mask(ocw2_level);
			end
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			auto_rotate_mode <= 1'b0;
		end else if (ocw2_write && (ocw2_code == ocw2_rotate_set)) begin
			auto_rotate_mode <= 1'b1;
		end else if (ocw2_write && (ocw2_code == ocw2_rotate_clear)) begin
			auto_rotate_mode <= 1'b0;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			priority_rotate <= '1; // level 7 lowest, so level 0 is highest.
		end else if (auto_rotate_mode && end_of_acknowledge_sequence) begin
			priority_rotate <= mask_to_level(acknowledge_interrupt);
		end else if (ocw2_write && (ocw2_code[2:1] == ocw2_set_priority)) begin
			priority_rotate <= ocw2_level;
		end else if (ocw2_write && (ocw2_code == ocw2_rotate_on_eoi)) begin
			priority_rotate <= mask_to_level(highest_level_in_service);
		end
	end

endmodule

`default_nettype wire

//--- source/pic_init_registers.sv
`default_nettype none

module pic_init_registers
	import pic_types_pkg::*;
	import pic_command_pkg::*;
(
	input logic clock,
	input logic reset,
	input data_byte_t internal_data_bus,
	input logic write_initial_command_word_1,
	input logic write_initial_command_word_2_4,
	output logic command_ready,
	output logic level_or_edge_triggered_config,
	output logic special_fully_nest_config,
	output logic auto_eoi_config,
	output vector_base_t vector_base
);

	typedef enum logic [1:0] {
		init_done,
		init_expect_icw2,
		init_expect_icw4
	} init_state_t;

	init_state_t init_state;
	logic set_icw4_config;
	logic write_icw2;
	logic write_icw4;

	assign write_icw2 = write_initial_command_word_2_4 && (init_state == init_expect_icw2);
	assign write_icw4 = write_initial_command_word_2_4 && (init_state == init_expect_icw4);
	assign command_ready = (init_state == init_done);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			init_state <= init_done;
		end else if (write_initial_command_word_1) begin
			init_state <= init_expect_icw2;
		end else if (write_icw2) begin
			init_state <= set_icw4_config ? init_expect_icw4 : init_done;
		end else if (write_icw4) begin
			init_state <= init_done;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			level_or_edge_triggered_config <= 1'b0;
			set_icw4_config <= 1'b0;
			vector_base <= '0;
			special_fully_nest_config <= 1'b0;
			auto_eoi_config <= 1'b0;
		end else begin
			if (write_initial_command_word_1) begin
				level_or_edge_triggered_config <= internal_data_bus[icw1_ltim_bit];
				set_icw4_config <= internal_data_bus[icw1_ic4_bit];
			end
			if (write_icw2) begin
				vector_base <= internal_data_bus[data_width-1:level_index_width]; // 8086 format.
			end
			if (write_icw4) begin
				special_fully_nest_config <= internal_data_bus[icw4_sfnm_bit];
				auto_eoi_config <= internal_data_bus[icw4_aeoi_bit];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pic_command_pkg.sv
`default_nettype none

package pic_command_pkg;

	// icw1 and icw4 fields.
	localparam int icw1_ltim_bit = 3;
	localparam int icw1_ic4_bit = 0;
	localparam int icw4_sfnm_bit = 4;
	localparam int icw4_aeoi_bit = 1;

	// ocw3 fields.
	localparam int ocw3_poll_bit = 2;
	localparam int ocw3_rr_bit = 1;
	localparam int ocw3_ris_bit = 0;

	// ocw2 code in bits 7..5 and level in bits 2..0.
	localparam int ocw2_code_lsb = 5;
	localparam int ocw2_level_lsb = 0;

	localparam logic [2:0] ocw2_rotate_clear = 3'b000;
	localparam logic [2:0] ocw2_nonspecific_eoi = 3'b001;
	localparam logic [2:0] ocw2_rotate_set = 3'b100;
	localparam logic [2:0] ocw2_rotate_on_eoi = 3'b101;
	localparam logic [2:0] ocw2_specific_eoi = 3'b011;
	localparam logic [1:0] ocw2_set_priority = 2'b11; // top two code bits of 110 and 111.

	localparam logic [4:0] poll_marker = 5'b10000;

	typedef enum logic [1:0] {
		idle,
		ack_first,
		ack_second,
		poll
	} ack_state_t;

endpackage

`default_nettype wire

//--- source/pic_types_pkg.sv
`default_nettype none

package pic_types_pkg;

	localparam int level_count = 8;
	localparam int level_index_width = 3;
	localparam int data_width = 8;
	localparam int vector_base_width = data_width - level_index_width;

	typedef logic [level_count-1:0] level_mask_t;
	typedef logic [level_index_width-1:0] level_index_t;
	typedef logic [data_width-1:0] data_byte_t;
	typedef logic [vector_base_width-1:0] vector_base_t;

	function automatic level_mask_t level_to_mask(input level_index_t index);
		return level_mask_t'(1) << index;
	endfunction

	// lowest set bit wins and an empty mask gives the last level.
	function automatic level_index_t mask_to_level(input level_mask_t mask);
		level_index_t index;
		index = level_index_t'(level_count - 1);
		for (int i = level_count - 1; i >= 0; i--) begin
			if (mask[i]) begin
				index = level_index_t'(i);
			end
		end
		return index;
	endfunction

endpackage

`default_nettype wire
